/* list.f */
src/i3c_target_pkg.sv
src/i3c_bus_evt_if.sv
src/i3c_shift_if.sv
src/i3c_bus_sampler.sv
src/i3c_bit_shifter.sv
src/i3c_target_fsm.sv
src/i3c_target_top.sv
dv/tb_clk_gen.sv
dv/tb_i3c_target.sv

/* Bender.yml */
package:
  name: i3c_target

sources:
  - src/i3c_target_pkg.sv
  - src/i3c_bus_evt_if.sv
  - src/i3c_shift_if.sv
  - src/i3c_bus_sampler.sv
  - src/i3c_bit_shifter.sv
  - src/i3c_target_fsm.sv
  - src/i3c_target_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_i3c_target.sv

/* dv/tb_i3c_target.sv */
// ****************************************
// Directed testbench for the serial target top
// Host model drives SCL and SDA, 8 clocks per phase
// thd_dat_i fixed at 3, SDA is a wired-AND bus
// ****************************************

`timescale 1ns/1ps

module tb_i3c_target;

  localparam int unsigned BW      = i3c_target_pkg::ByteWidth;
  localparam int unsigned Phase   = 8;
  localparam int unsigned Timeout = 200;
  localparam logic [i3c_target_pkg::AddrWidth-1:0] TgtAddr = 7'h2d;

  logic                                           clk;
  logic                                           rst_n;
  logic                                           target_enable;
  logic [i3c_target_pkg::AddrWidth-1:0]           target_addr;
  logic [i3c_target_pkg::HoldCntWidthDefault-1:0] thd_dat;
  logic                                           scl_drv;
  logic                                           sda_host;
  logic                                           sda_bus;
  logic [BW-1:0]                                  tx_data;
  logic                                           tx_pop;
  logic                                           rx_valid;
  i3c_target_pkg::rx_entry_t                      rx_entry;
  logic                                           sda_o;
  logic                                           transmitting;
  logic                                           idle;
  logic                                           ev_cmd;
  logic                                           ev_read;
  logic                                           ev_unexp;

  // Observed RX entries and pulse counts per test
  i3c_target_pkg::rx_entry_t rx_q[$];
  int                        cmd_cnt;
  int                        read_cnt;
  int                        unexp_cnt;
  int                        pop_cnt;
  int                        sda_low_cnt;
  int                        checks;
  int                        errors;
  integer                    seed;

  // Open drain, either side can pull SDA low
  assign sda_bus = sda_host & sda_o;

  tb_clk_gen #(
    .PeriodNs (40)
  ) u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  i3c_target_top #(
    .HoldCntWidth (i3c_target_pkg::HoldCntWidthDefault)
  ) DUT (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .target_enable_i       (target_enable),
    .target_addr_i         (target_addr),
    .thd_dat_i             (thd_dat),
    .scl_i                 (scl_drv),
    .sda_i                 (sda_bus),
    .tx_data_i             (tx_data),
    .tx_pop_o              (tx_pop),
    .rx_valid_o            (rx_valid),
    .rx_entry_o            (rx_entry),
    .sda_o                 (sda_o),
    .target_transmitting_o (transmitting),
    .target_idle_o         (idle),
    .event_cmd_complete_o  (ev_cmd),
    .event_read_cmd_o      (ev_read),
    .event_unexp_stop_o    (ev_unexp)
  );

  // Monitor, outputs are settled at the clock edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (rx_valid) begin
        rx_q.push_back(rx_entry);
      end
      cmd_cnt     += ev_cmd;
      read_cnt    += ev_read;
      unexp_cnt   += ev_unexp;
      pop_cnt     += tx_pop;
      sda_low_cnt += !sda_o;
    end
  end

  // Advance n clocks, then a short skew for driving
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  function automatic logic [BW-1:0] rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[BW-1:0];
  endfunction

  task automatic clear_counts();
    rx_q.delete();
    cmd_cnt     = 0;
    read_cnt    = 0;
    unexp_cnt   = 0;
    pop_cnt     = 0;
    sda_low_cnt = 0;
  endtask

  task automatic check_entry(input i3c_target_pkg::rx_entry_t got,
                             input i3c_target_pkg::rx_entry_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got fmt %0d data %h, expected fmt %0d data %h",
               $time, what, got.fmt, got.data, exp.fmt, exp.data);
    end
  endtask

  task automatic check_byte(input logic [BW-1:0] got, input logic [BW-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERR %0t: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Pulse counts of events and TX pops
  task automatic check_events(input int cmd, input int rd, input int unexp, input int pop,
                              input string what);
    check_count(cmd_cnt, cmd, {what, " cmd complete pulses"});
    check_count(read_cnt, rd, {what, " read cmd pulses"});
    check_count(unexp_cnt, unexp, {what, " unexpected stop pulses"});
    check_count(pop_cnt, pop, {what, " tx pops"});
  endtask

  task automatic expect_entry(input i3c_target_pkg::rx_fmt_e fmt, input logic [BW-1:0] data,
                              input string what);
    i3c_target_pkg::rx_entry_t exp;
    exp = '{fmt: fmt, data: data};
    if (rx_q.size() == 0) begin
      errors++;
      $display("No RX entry arrived for %s by %0t", what, $time);
    end else begin
      check_entry(rx_q.pop_front(), exp, what);
    end
  endtask

  task automatic wait_entries(input int n);
    int i;
    i = 0;
    while (rx_q.size() < n && i < Timeout) begin
      step(1);
      i++;
    end
    if (rx_q.size() < n) begin
      errors++;
      $display("Timeout: only %0d of %0d RX entries arrived", rx_q.size(), n);
    end
  endtask

  task automatic wait_idle();
    int i;
    i = 0;
    while (idle !== 1'b1 && i < Timeout) begin
      step(1);
      i++;
    end
    if (idle !== 1'b1) begin
      errors++;
      $display("Timeout: target did not return to idle by %0t", $time);
    end
  endtask

  // One bit, data moves in SCL low, sampled mid SCL high
  task automatic clock_bit(input logic b, output logic seen);
    step(2);
    sda_host = b;
    step(Phase - 2);
    scl_drv = 1'b1;
    step(Phase / 2);
    seen = sda_bus;
    step(Phase / 2);
    scl_drv = 1'b0;
  endtask

  task automatic bus_start();
    sda_host = 1'b0;
    step(Phase);
    scl_drv = 1'b0;
  endtask

  task automatic bus_restart();
    step(2);
    sda_host = 1'b1;
    step(Phase - 2);
    scl_drv = 1'b1;
    step(Phase);
    sda_host = 1'b0;
    step(Phase);
    scl_drv = 1'b0;
  endtask

  task automatic bus_stop();
    step(2);
    sda_host = 1'b0;
    step(Phase - 2);
    scl_drv = 1'b1;
    step(Phase);
    sda_host = 1'b1;
    step(Phase);
  endtask

  // Host releases SDA on the ninth bit, low there is ACK
  task automatic send_byte(input logic [BW-1:0] b, output logic acked);
    logic seen;
    for (int i = BW - 1; i >= 0; i--) begin
      clock_bit(b[i], seen);
    end
    clock_bit(1'b1, seen);
    acked = !seen;
  endtask

  task automatic read_byte(input logic ack, output logic [BW-1:0] b);
    logic seen;
    for (int i = BW - 1; i >= 0; i--) begin
      clock_bit(1'b1, seen);
      b[i] = seen;
    end
    clock_bit(!ack, seen);
  endtask

  task automatic test_reset();
    check_bit(sda_o, 1'b1, "reset sda_o");
    check_bit(idle, 1'b1, "reset idle");
    check_bit(transmitting, 1'b0, "reset transmitting");
    check_bit(rx_valid, 1'b0, "reset rx_valid");
    check_bit(tx_pop, 1'b0, "reset tx_pop");
    check_bit(ev_cmd, 1'b0, "reset cmd complete");
    check_bit(ev_read, 1'b0, "reset read cmd");
    check_bit(ev_unexp, 1'b0, "reset unexpected stop");
  endtask

  task automatic test_write();
    logic [BW-1:0] data [3];
    logic          acked;
    clear_counts();
    bus_start();
    send_byte({TgtAddr, 1'b0}, acked);
    check_bit(acked, 1'b1, "write address ACK");
    for (int k = 0; k < 3; k++) begin
      data[k] = rand_byte();
      send_byte(data[k], acked);
      check_bit(acked, 1'b1, "write data ACK");
    end
    bus_stop();
    wait_entries(5);
    wait_idle();
    expect_entry(i3c_target_pkg::RxStart, {TgtAddr, 1'b0}, "write address entry");
    for (int k = 0; k < 3; k++) begin
      expect_entry(i3c_target_pkg::RxData, data[k], "write data entry");
    end
    expect_entry(i3c_target_pkg::RxStop, '0, "write stop entry");
    check_count(rx_q.size(), 0, "extra entries after write");
    check_events(1, 0, 0, 0, "write");
  endtask

  task automatic test_mismatch();
    logic acked;
    clear_counts();
    bus_start();
    send_byte({TgtAddr ^ 7'h01, 1'b0}, acked);
    check_bit(acked, 1'b0, "mismatch address NACK");
    send_byte(rand_byte(), acked);
    check_bit(acked, 1'b0, "mismatch data NACK");
    bus_stop();
    wait_idle();
    check_count(sda_low_cnt, 0, "mismatch sda_o low cycles");
    check_count(rx_q.size(), 0, "mismatch entries");
    check_events(0, 0, 0, 0, "mismatch");
  endtask

  // Host ACKs two bytes, NACKs the third
  task automatic test_read();
    logic [BW-1:0] data [3];
    logic [BW-1:0] got;
    logic          acked;
    clear_counts();
    for (int k = 0; k < 3; k++) begin
      data[k] = rand_byte();
    end
    tx_data = data[0];
    bus_start();
    send_byte({TgtAddr, 1'b1}, acked);
    check_bit(acked, 1'b1, "read address ACK");
    for (int k = 0; k < 3; k++) begin
      tx_data = data[k];
      read_byte(k < 2, got);
      check_byte(got, data[k], "read data byte");
    end
    bus_stop();
    wait_entries(2);
    wait_idle();
    expect_entry(i3c_target_pkg::RxStart, {TgtAddr, 1'b1}, "read address entry");
    expect_entry(i3c_target_pkg::RxStop, '0, "read stop entry");
    check_count(rx_q.size(), 0, "extra entries after read");
    check_events(1, 1, 0, 3, "read");
  endtask

  // Write, Sr, read, STOP right after a host ACK
  task automatic test_restart();
    logic [BW-1:0] wdata;
    logic [BW-1:0] rdata;
    logic [BW-1:0] got;
    logic          acked;
    clear_counts();
    wdata = rand_byte();
    rdata = rand_byte();
    bus_start();
    send_byte({TgtAddr, 1'b0}, acked);
    check_bit(acked, 1'b1, "restart write address ACK");
    send_byte(wdata, acked);
    check_bit(acked, 1'b1, "restart write data ACK");
    bus_restart();
    tx_data = rdata;
    send_byte({TgtAddr, 1'b1}, acked);
    check_bit(acked, 1'b1, "restart read address ACK");
    read_byte(1'b1, got);
    check_byte(got, rdata, "read byte after Sr");
    // Next byte leads with 1 so SDA is free for STOP
    tx_data = rand_byte() | 8'h80;
    bus_stop();
    wait_entries(4);
    wait_idle();
    expect_entry(i3c_target_pkg::RxStart, {TgtAddr, 1'b0}, "restart first address");
    expect_entry(i3c_target_pkg::RxData, wdata, "restart write data");
    expect_entry(i3c_target_pkg::RxRestart, {TgtAddr, 1'b1}, "restart read address");
    expect_entry(i3c_target_pkg::RxStop, '0, "restart stop entry");
    check_count(rx_q.size(), 0, "extra entries after restart");
    check_events(2, 1, 1, 1, "restart");
  endtask

  task automatic test_disable();
    logic [BW-1:0] addr_byte;
    logic          seen;
    clear_counts();
    addr_byte = {TgtAddr, 1'b0};
    bus_start();
    for (int i = 0; i < BW; i++) begin
      clock_bit(addr_byte[BW-1-i], seen);
      // Drop enable after the fourth address bit
      if (i == 3) begin
        target_enable = 1'b0;
        wait_idle();
      end
    end
    clock_bit(1'b1, seen);
    check_bit(seen, 1'b1, "ACK bit after disable");
    bus_stop();
    check_bit(idle, 1'b1, "idle after disable");
    check_count(sda_low_cnt, 0, "disable sda_o low cycles");
    check_count(rx_q.size(), 0, "disable entries");
    check_events(0, 0, 0, 0, "disable");
    target_enable = 1'b1;
    step(2);
  endtask

  initial begin
    int i;
    seed          = 32'hd451_6418;
    checks        = 0;
    errors        = 0;
    target_enable = 1'b1;
    target_addr   = TgtAddr;
    thd_dat       = 3;
    scl_drv       = 1'b1;
    sda_host      = 1'b1;
    tx_data       = '0;
    clear_counts();
    i = 0;
    while (rst_n !== 1'b1 && i < Timeout) begin
      step(1);
      i++;
    end
    if (rst_n !== 1'b1) begin
      errors++;
      $display("Timeout: reset was never released");
    end
    step(1);
    test_reset();
    test_write();
    test_mismatch();
    test_read();
    test_restart();
    test_disable();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* dv/tb_clk_gen.sv */
// ****************************************
// Testbench clock and reset source
// Reset held low for two clock cycles
// ****************************************

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs = 40
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    // Release just after the edge, away from the flops
    #2;
    rst_no = 1'b1;
  end

  // Free-running clock
  always #(PeriodNs / 2) clk_o = ~clk_o;

endmodule

/* src/i3c_target_top.sv */
// ****************************************
// Serial target top, sampler to shifter to FSM
// scl_i and sda_i must be synchronous to clk_i
// sda_o high means released, SCL is input only
// ****************************************

`timescale 1ns/1ps

module i3c_target_top #(
  parameter int unsigned HoldCntWidth = i3c_target_pkg::HoldCntWidthDefault
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 target_enable_i,
  input  logic [i3c_target_pkg::AddrWidth-1:0] target_addr_i,
  input  logic [HoldCntWidth-1:0]              thd_dat_i,
  input  logic                                 scl_i,
  input  logic                                 sda_i,
  input  logic [i3c_target_pkg::ByteWidth-1:0] tx_data_i,
  output logic                                 tx_pop_o,
  output logic                                 rx_valid_o,
  output i3c_target_pkg::rx_entry_t            rx_entry_o,
  output logic                                 sda_o,
  output logic                                 target_transmitting_o,
  output logic                                 target_idle_o,
  output logic                                 event_cmd_complete_o,
  output logic                                 event_read_cmd_o,
  output logic                                 event_unexp_stop_o
);

  // Bus events and byte-level link
  i3c_bus_evt_if bus_evt ();
  i3c_shift_if   shift ();

  i3c_bus_sampler u_sampler (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .scl_i  (scl_i),
    .sda_i  (sda_i),
    .evt    (bus_evt)
  );

  i3c_bit_shifter u_shifter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .evt    (bus_evt),
    .sh     (shift)
  );

  i3c_target_fsm #(
    .HoldCntWidth (HoldCntWidth)
  ) u_fsm (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .target_enable_i       (target_enable_i),
    .target_addr_i         (target_addr_i),
    .thd_dat_i             (thd_dat_i),
    .evt                   (bus_evt),
    .sh                    (shift),
    .tx_data_i             (tx_data_i),
    .tx_pop_o              (tx_pop_o),
    .rx_valid_o            (rx_valid_o),
    .rx_entry_o            (rx_entry_o),
    .sda_o                 (sda_o),
    .target_transmitting_o (target_transmitting_o),
    .target_idle_o         (target_idle_o),
    .event_cmd_complete_o  (event_cmd_complete_o),
    .event_read_cmd_o      (event_read_cmd_o),
    .event_unexp_stop_o    (event_unexp_stop_o)
  );

endmodule

/* src/i3c_target_fsm.sv */
// ****************************************
// Target protocol FSM for I2C-style transfers
// thd_dat_i must be 2 or more and below SCL low time
// No clock stretching, SCL is never driven
// sda_o is open drain style, 1 means released
// ****************************************

`timescale 1ns/1ps

module i3c_target_fsm #(
  parameter int unsigned HoldCntWidth = i3c_target_pkg::HoldCntWidthDefault
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 target_enable_i,
  input  logic [i3c_target_pkg::AddrWidth-1:0] target_addr_i,
  input  logic [HoldCntWidth-1:0]              thd_dat_i,
  i3c_bus_evt_if.dst                           evt,
  i3c_shift_if.ctrl                            sh,
  input  logic [i3c_target_pkg::ByteWidth-1:0] tx_data_i,
  output logic                                 tx_pop_o,
  output logic                                 rx_valid_o,
  output i3c_target_pkg::rx_entry_t            rx_entry_o,
  output logic                                 sda_o,
  output logic                                 target_transmitting_o,
  output logic                                 target_idle_o,
  output logic                                 event_cmd_complete_o,
  output logic                                 event_read_cmd_o,
  output logic                                 event_unexp_stop_o
);

  localparam int unsigned BW   = i3c_target_pkg::BitIdxWidth;
  localparam int unsigned SelW = $clog2(i3c_target_pkg::ByteWidth);
  // Last data bit before the ACK bit
  localparam logic [BW-1:0] LastBitIdx = BW'(i3c_target_pkg::ByteWidth - 1);

  typedef enum logic [4:0] {
    Idle,
    AcquireStart,
    AddrRead,
    AddrAckWait,
    AddrAckSetup,
    AddrAckPulse,
    AddrAckHold,
    TransmitWait,
    TransmitSetup,
    TransmitPulse,
    TransmitHold,
    TransmitAck,
    TransmitAckPulse,
    AcquireByte,
    AcquireAckWait,
    AcquireAckSetup,
    AcquireAckPulse,
    AcquireAckHold,
    WaitForStop
  } state_e;

  state_e                  state_q;
  state_e                  state_d;
  logic [HoldCntWidth-1:0] hold_cnt_q;
  logic                    load_hold;
  logic                    hold_done;
  logic                    rw_bit_q;
  logic                    rw_bit_d;
  logic                    xact_for_us_q;
  logic                    xact_for_us_d;
  logic                    xfer_for_us_q;
  logic                    xfer_for_us_d;
  logic                    restart_q;
  logic                    restart_d;
  logic                    stop_pend_q;
  logic                    sda_q;
  logic                    addr_match;
  logic                    tx_bit;
  logic                    byte_end_fall;

  assign hold_done  = (hold_cnt_q == HoldCntWidth'(1));
  assign addr_match = (sh.rx_byte[i3c_target_pkg::ByteWidth-1:1] == target_addr_i);
  // MSB first, bit_idx 0 selects bit 7
  assign tx_bit = tx_data_i[~sh.bit_idx[SelW-1:0]];
  // SCL fall that closes bit 7
  assign byte_end_fall = evt.scl_fall && (sh.bit_idx == LastBitIdx);
  assign target_idle_o = (state_q == Idle);

  // Hold timer, counts down to 1 then parks at 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_cnt_q <= '0;
    end else if (load_hold) begin
      hold_cnt_q <= thd_dat_i;
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - HoldCntWidth'(1);
    end
  end

  always_comb begin
    state_d               = state_q;
    load_hold             = 1'b0;
    sh.byte_clr           = 1'b0;
    sda_o                 = 1'b1;
    target_transmitting_o = 1'b0;
    tx_pop_o              = 1'b0;
    rx_valid_o            = 1'b0;
    rx_entry_o            = '{fmt: i3c_target_pkg::RxData, data: sh.rx_byte};
    event_cmd_complete_o  = 1'b0;
    event_read_cmd_o      = 1'b0;
    rw_bit_d              = rw_bit_q;
    xact_for_us_d         = xact_for_us_q;
    xfer_for_us_d         = xfer_for_us_q;
    restart_d             = restart_q;

    unique case (state_q)
      Idle: begin
        xact_for_us_d = 1'b0;
        xfer_for_us_d = 1'b0;
      end
      // First SCL low ends the START, counter restarts here
      AcquireStart: begin
        xfer_for_us_d = 1'b0;
        if (!evt.scl) begin
          sh.byte_clr = 1'b1;
          state_d     = AddrRead;
        end
      end
      AddrRead: begin
        load_hold = byte_end_fall;
        if (sh.bit_ack) begin
          rw_bit_d = sh.rx_byte[0];
          if (addr_match) begin
            xact_for_us_d = 1'b1;
            xfer_for_us_d = 1'b1;
            state_d       = AddrAckWait;
          end else begin
            state_d = WaitForStop;
          end
        end
      end
      AddrAckWait, AcquireAckWait: begin
        if (evt.scl) begin
          // Host too fast for the hold time, give up on this transfer
          state_d = WaitForStop;
        end else if (hold_done) begin
          sda_o                 = 1'b0;
          target_transmitting_o = 1'b1;
          state_d = (state_q == AddrAckWait) ? AddrAckSetup : AcquireAckSetup;
        end
      end
      AddrAckSetup, AcquireAckSetup: begin
        sda_o                 = 1'b0;
        target_transmitting_o = 1'b1;
        if (evt.scl) begin
          state_d = (state_q == AddrAckSetup) ? AddrAckPulse : AcquireAckPulse;
        end
      end
      AddrAckPulse, AcquireAckPulse: begin
        sda_o                 = 1'b0;
        target_transmitting_o = 1'b1;
        if (evt.scl_fall) begin
          load_hold = 1'b1;
          state_d   = (state_q == AddrAckPulse) ? AddrAckHold : AcquireAckHold;
        end
      end
      // Release SDA and report the byte once the hold time is over
      AddrAckHold, AcquireAckHold: begin
        if (hold_done) begin
          rx_valid_o = 1'b1;
          state_d    = AcquireByte;
          if (state_q == AddrAckHold) begin
            rx_entry_o.fmt   = restart_q ? i3c_target_pkg::RxRestart
                                         : i3c_target_pkg::RxStart;
            event_read_cmd_o = rw_bit_q;
            if (rw_bit_q) begin
              state_d = TransmitWait;
            end
          end
        end else begin
          sda_o                 = 1'b0;
          target_transmitting_o = 1'b1;
        end
      end
      TransmitWait: begin
        state_d = TransmitSetup;
      end
      // Bit follows tx_data_i until SCL rises
      TransmitSetup: begin
        sda_o                 = tx_bit;
        target_transmitting_o = 1'b1;
        if (evt.scl) begin
          state_d = TransmitPulse;
        end
      end
      TransmitPulse: begin
        sda_o                 = sda_q;
        target_transmitting_o = 1'b1;
        if (evt.scl_fall) begin
          load_hold = 1'b1;
          state_d   = TransmitHold;
        end
      end
      // Keep the old bit for the hold time, then move on
      TransmitHold: begin
        sda_o                 = sda_q;
        target_transmitting_o = 1'b1;
        if (hold_done) begin
          if (sh.bit_ack) begin
            sda_o                 = 1'b1;
            target_transmitting_o = 1'b0;
            state_d               = TransmitAck;
          end else begin
            sda_o   = tx_bit;
            state_d = TransmitSetup;
          end
        end
      end
      TransmitAck: begin
        if (evt.scl) begin
          state_d = TransmitAckPulse;
        end
      end
      // Pop on ACK and NACK alike, NACK ends the read
      TransmitAckPulse: begin
        if (evt.scl_fall) begin
          tx_pop_o = 1'b1;
          state_d  = sh.host_ack ? TransmitWait : WaitForStop;
        end
      end
      AcquireByte: begin
        load_hold = byte_end_fall;
        if (sh.bit_ack) begin
          state_d = AcquireAckWait;
        end
      end
      WaitForStop: begin
        state_d = WaitForStop;
      end
      default: begin
        state_d = Idle;
      end
    endcase

    // Disable, START and STOP take over from any state
    if (!target_enable_i && (state_q != Idle)) begin
      state_d = Idle;
    end else if (target_enable_i && evt.start_det) begin
      state_d              = AcquireStart;
      restart_d            = (state_q != Idle);
      event_cmd_complete_o = xfer_for_us_q;
    end else if (target_enable_i && evt.stop_det) begin
      state_d              = Idle;
      event_cmd_complete_o = xfer_for_us_q;
    end

    // Stop entry one cycle after the STOP
    if (stop_pend_q) begin
      rx_valid_o = 1'b1;
      rx_entry_o = '{fmt: i3c_target_pkg::RxStop, data: '0};
    end
  end

  // STOP inside an addressed read without a host NACK
  assign event_unexp_stop_o = target_enable_i & evt.stop_det & xfer_for_us_q &
                              rw_bit_q & (state_q != WaitForStop);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= Idle;
      rw_bit_q      <= 1'b0;
      xact_for_us_q <= 1'b0;
      xfer_for_us_q <= 1'b0;
      restart_q     <= 1'b0;
      stop_pend_q   <= 1'b0;
      sda_q         <= 1'b1;
    end else begin
      state_q       <= state_d;
      rw_bit_q      <= rw_bit_d;
      xact_for_us_q <= xact_for_us_d;
      xfer_for_us_q <= xfer_for_us_d;
      restart_q     <= restart_d;
      stop_pend_q   <= target_enable_i & evt.stop_det & xact_for_us_q;
      sda_q         <= sda_o;
    end
  end

  // SDA pulled low only while flagged as transmitting
  sda_low_xmit_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !sda_o |-> target_transmitting_o
  );

  // RX report and TX pop never share a cycle
  rx_tx_excl_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(rx_valid_o && tx_pop_o)
  );

endmodule

/* src/i3c_bit_shifter.sv */
// ****************************************
// Per-byte bit counter and MSB-first input shifter
// Counter steps after each SCL fall, wraps after ACK
// Shift register has no reset, START clears it
// ****************************************

`timescale 1ns/1ps

module i3c_bit_shifter (
  input  logic         clk_i,
  input  logic         rst_ni,
  i3c_bus_evt_if.dst   evt,
  i3c_shift_if.shifter sh
);

  localparam int unsigned BW = i3c_target_pkg::BitIdxWidth;
  // Index of the ninth bit
  localparam logic [BW-1:0] AckIdx = BW'(i3c_target_pkg::ByteWidth);

  logic [BW-1:0]                        bit_idx_q;
  logic [i3c_target_pkg::ByteWidth-1:0] rx_byte_q;
  logic                                 host_ack_q;
  logic                                 bit_ack;

  assign bit_ack = (bit_idx_q == AckIdx);

  // Bit counter, clear wins over SCL fall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_idx_q <= '0;
    end else if (evt.start_det || sh.byte_clr) begin
      bit_idx_q <= '0;
    end else if (evt.scl_fall) begin
      bit_idx_q <= bit_ack ? '0 : bit_idx_q + BW'(1);
    end
  end

  // Data bits enter on SCL rise, ACK bit skipped
  always_ff @(posedge clk_i) begin
    if (evt.start_det || sh.byte_clr) begin
      rx_byte_q <= '0;
    end else if (evt.scl_rise && !bit_ack) begin
      rx_byte_q <= {rx_byte_q[i3c_target_pkg::ByteWidth-2:0], evt.sda};
    end
  end

  // Low SDA on the ninth bit means ACK
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      host_ack_q <= 1'b0;
    end else if (evt.scl_rise && bit_ack) begin
      host_ack_q <= ~evt.sda;
    end
  end

  assign sh.bit_idx  = bit_idx_q;
  assign sh.bit_ack  = bit_ack;
  assign sh.rx_byte  = rx_byte_q;
  assign sh.host_ack = host_ack_q;

  // Counter never leaves 0..8
  bit_idx_range_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bit_idx_q <= AckIdx
  );

endmodule

/* src/i3c_bus_sampler.sv */
// ****************************************
// SCL and SDA sampler with edge and condition detect
// Inputs must already be synchronous to clk_i
// Events show one clock after the line change
// ****************************************

`timescale 1ns/1ps

module i3c_bus_sampler (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       scl_i,
  input  logic       sda_i,
  i3c_bus_evt_if.src evt
);

  // Current samples
  logic scl_q;
  logic sda_q;

  // Samples one clock older
  logic scl_p;
  logic sda_p;

  // Idle bus is high on both lines
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q <= 1'b1;
      sda_q <= 1'b1;
      scl_p <= 1'b1;
      sda_p <= 1'b1;
    end else begin
      scl_q <= scl_i;
      sda_q <= sda_i;
      scl_p <= scl_q;
      sda_p <= sda_q;
    end
  end

  assign evt.scl = scl_q;
  assign evt.sda = sda_q;

  // Edges from old and new sample
  assign evt.scl_rise = scl_q & ~scl_p;
  assign evt.scl_fall = ~scl_q & scl_p;

  // SCL must be high in both samples
  // SDA falling marks START or Sr, rising marks STOP
  assign evt.start_det = scl_q & scl_p & sda_p & ~sda_q;
  assign evt.stop_det  = scl_q & scl_p & ~sda_p & sda_q;

  // START and STOP are exclusive in any one cycle
  start_stop_excl_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(evt.start_det && evt.stop_det)
  );

endmodule

/* src/i3c_shift_if.sv */
// ****************************************
// Link between bit shifter and protocol FSM
// byte_clr is a one-cycle strobe from the FSM
// ****************************************

`timescale 1ns/1ps

interface i3c_shift_if;

  // Clears shift register and bit counter
  logic byte_clr;

  // Bit position within the byte, 8 is the ACK bit
  logic [i3c_target_pkg::BitIdxWidth-1:0] bit_idx;
  logic                                   bit_ack;

  // Bits taken in so far, MSB first
  logic [i3c_target_pkg::ByteWidth-1:0] rx_byte;

  // Host answer on the ACK bit of a read byte
  logic host_ack;

  modport shifter (input byte_clr, output bit_idx, bit_ack, rx_byte, host_ack);
  modport ctrl (output byte_clr, input bit_idx, bit_ack, rx_byte, host_ack);

endinterface

/* src/i3c_bus_evt_if.sv */
// ****************************************
// Sampled bus levels and single-cycle bus events
// All pulses are strobes with no back-pressure
// ****************************************

`timescale 1ns/1ps

interface i3c_bus_evt_if;

  // Registered line levels
  logic scl;
  logic sda;

  // Edge strobes on SCL
  logic scl_rise;
  logic scl_fall;

  // Bus conditions, SDA moving while SCL stays high
  logic start_det;
  logic stop_det;

  modport src (output scl, sda, scl_rise, scl_fall, start_det, stop_det);
  modport dst (input scl, sda, scl_rise, scl_fall, start_det, stop_det);

endinterface

/* src/i3c_target_pkg.sv */
// ****************************************
// Shared widths and RX entry format for the serial target
// Static 7-bit addressing only, one byte per RX entry
// RX tag encoding follows the acquire FIFO format
// ****************************************

package i3c_target_pkg;

  // Bits per bus byte
  parameter int unsigned ByteWidth = 8;

  // Static target address width
  parameter int unsigned AddrWidth = 7;

  // Bit counter runs 0 to 8, the last count is the ACK bit
  parameter int unsigned BitIdxWidth = 4;

  // Default width of the data hold count
  parameter int unsigned HoldCntWidthDefault = 13;

  // Framing tag of an RX entry
  typedef enum logic [1:0] {
    RxData    = 2'b00,
    RxStart   = 2'b01,
    RxStop    = 2'b10,
    RxRestart = 2'b11
  } rx_fmt_e;

  // One RX entry, tag above the byte
  typedef struct packed {
    rx_fmt_e              fmt;
    logic [ByteWidth-1:0] data;
  } rx_entry_t;

endpackage
